//--- filelist.f
logic/div_pkg.sv
logic/div_dispatch.sv
logic/div_lane.sv
logic/div_collect.sv
logic/div_unit_top.sv
test/div_unit_assertions.sv
test/div_unit_tb.sv

//--- logic/div_collect.sv
module div_collect import div_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_i,

    input  logic [NUM_LANES-1:0] done_i,
    input  div_res_t             lane_res_i [NUM_LANES],

    output logic [NUM_LANES-1:0] take_o,
    output logic                 res_valid_o,
    output div_res_t             res_o
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] sel_idx;
    logic [PTR_W-1:0] ptr_next;
    logic             sel_found;
    logic             res_valid_q;
    div_res_t         res_q;

    // first done lane at or after the pointer
    always_comb begin
        int idx;
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            idx = (int'(ptr_q) + i) % NUM_LANES;
            if (!sel_found && done_i[idx]) begin
                sel_found = 1'b1;
                sel_idx   = PTR_W'(idx);
            end
        end
    end

    always_comb begin
        take_o = '0;
        if (sel_found) begin
            take_o[sel_idx] = 1'b1;
        end
    end

    // winner gets lowest priority next time
    assign ptr_next = (int'(sel_idx) == NUM_LANES - 1) ? '0 : sel_idx + 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            ptr_q       <= '0;
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= sel_found;
            if (sel_found) begin
                ptr_q <= ptr_next;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sel_found) begin
            res_q <= lane_res_i[sel_idx];
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

endmodule

//--- logic/div_dispatch.sv
module div_dispatch import div_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_i,

    input  logic                 req_valid_i,
    input  div_req_t             req_i,
    input  logic [NUM_LANES-1:0] idle_i,

    output logic [NUM_LANES-1:0] start_o,
    output div_req_t             lane_req_o,
    output logic                 busy_o
);

    logic [NUM_LANES-1:0] start_q;
    logic [NUM_LANES-1:0] avail;
    logic [NUM_LANES-1:0] pick;
    logic                 accept;
    div_req_t             req_q;

    // a lane started last cycle still shows idle, keep it out of the pick
    assign avail = idle_i & ~start_q;

    // lowest set bit of avail
    assign pick = avail & (~avail + {{(NUM_LANES-1){1'b0}}, 1'b1});

    assign busy_o = ~|avail;
    assign accept = req_valid_i & ~busy_o;   // strobe while busy is dropped

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            start_q <= '0;
        end else if (accept) begin
            start_q <= pick;
        end else begin
            start_q <= '0;   // single-cycle start
        end
    end

    // request payload, shared by all lanes
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

    assign start_o    = start_q;
    assign lane_req_o = req_q;

endmodule

//--- logic/div_lane.sv
module div_lane import div_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,

    input  logic     start_i,
    input  div_req_t req_i,
    input  logic     take_i,

    output logic     idle_o,
    output logic     done_o,
    output div_res_t res_o
);

    div_state_e state_q;

    logic [32:0]          a_q;      // partial remainder, bit 32 is the sign
    logic [31:0]          q_q;      // dividend shifting out, quotient shifting in
    logic [31:0]          m_q;      // divisor magnitude
    logic [4:0]           cnt_q;
    logic                 neg_quot_q;
    logic                 neg_rem_q;
    div_op_e              op_q;
    logic [DIV_TAG_W-1:0] tag_q;

    logic        req_signed;
    logic        div_zero;
    logic        overflow;
    logic [31:0] dvd_mag;
    logic [31:0] dvs_mag;
    logic        op_signed;
    logic        op_rem;
    logic [32:0] a_shift;
    logic [32:0] a_step;

    assign req_signed = (req_i.op == DIV) || (req_i.op == REM);
    assign div_zero   = (req_i.divisor == 32'd0);
    assign overflow   = req_signed && (req_i.dividend == 32'h8000_0000)
                        && (req_i.divisor == 32'hffff_ffff);

    assign dvd_mag = (req_signed && req_i.dividend[31]) ? (~req_i.dividend + 32'd1)
                                                        : req_i.dividend;
    assign dvs_mag = (req_signed && req_i.divisor[31]) ? (~req_i.divisor + 32'd1)
                                                       : req_i.divisor;

    assign op_signed = (op_q == DIV) || (op_q == REM);
    assign op_rem    = (op_q == REM) || (op_q == REMU);

    // one non-restoring step: add when negative, subtract otherwise
    assign a_shift = {a_q[31:0], q_q[31]};
    assign a_step  = a_q[32] ? (a_shift + {1'b0, m_q}) : (a_shift - {1'b0, m_q});

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        if (div_zero || overflow) begin
                            state_q <= DONE;   // answer is known already
                        end else begin
                            state_q <= ITERATE;
                        end
                    end
                end
                ITERATE: begin
                    if (cnt_q == 5'd0) begin
                        state_q <= RESTORE;
                    end
                end
                RESTORE: begin
                    state_q <= op_signed ? SIGN_FIX : DONE;
                end
                SIGN_FIX: begin
                    state_q <= DONE;
                end
                DONE: begin
                    if (take_i) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    op_q  <= req_i.op;
                    tag_q <= req_i.tag;
                    if (div_zero) begin
                        q_q <= 32'hffff_ffff;
                        a_q <= {1'b0, req_i.dividend};
                    end else if (overflow) begin
                        q_q <= req_i.dividend;
                        a_q <= '0;
                    end else begin
                        a_q        <= '0;
                        q_q        <= dvd_mag;
                        m_q        <= dvs_mag;
                        cnt_q      <= 5'd31;
                        neg_quot_q <= req_signed & (req_i.dividend[31] ^ req_i.divisor[31]);
                        neg_rem_q  <= req_signed & req_i.dividend[31];
                    end
                end
            end
            ITERATE: begin
                a_q   <= a_step;
                q_q   <= {q_q[30:0], ~a_step[32]};   // quotient bit set when still positive
                cnt_q <= cnt_q - 5'd1;
            end
            RESTORE: begin
                if (a_q[32]) begin
                    a_q <= a_q + {1'b0, m_q};
                end
            end
            SIGN_FIX: begin
                if (neg_quot_q) begin
                    q_q <= ~q_q + 32'd1;
                end
                if (neg_rem_q) begin
                    a_q <= {1'b0, ~a_q[31:0] + 32'd1};   // remainder follows the dividend
                end
            end
            default: begin
            end
        endcase
    end

    assign idle_o       = (state_q == IDLE);
    assign done_o       = (state_q == DONE);
    assign res_o.result = op_rem ? a_q[31:0] : q_q;
    assign res_o.tag    = tag_q;

endmodule

//--- logic/div_pkg.sv
package div_pkg;

    localparam int DIV_TAG_W = 4;   // request tag width, sizes the structs below

    // low two bits of the M-extension funct3
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_e;

    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        ITERATE  = 3'd1,
        RESTORE  = 3'd2,
        SIGN_FIX = 3'd3,
        DONE     = 3'd4
    } div_state_e;

    // one divide request, 70 bits
    typedef struct packed {
        div_op_e              op;
        logic [31:0]          dividend;
        logic [31:0]          divisor;
        logic [DIV_TAG_W-1:0] tag;
    } div_req_t;

    // one result, 36 bits
    typedef struct packed {
        logic [31:0]          result;
        logic [DIV_TAG_W-1:0] tag;
    } div_res_t;

endpackage

//--- logic/div_unit_top.sv
module div_unit_top import div_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic     clk_i,
    input  logic     rst_i,

    input  logic     req_valid_i,
    input  div_req_t req_i,
    output logic     busy_o,

    output logic     res_valid_o,
    output div_res_t res_o
);

    logic [NUM_LANES-1:0] start;
    logic [NUM_LANES-1:0] idle;
    logic [NUM_LANES-1:0] done;
    logic [NUM_LANES-1:0] take;
    div_req_t             lane_req;
    div_res_t             lane_res [NUM_LANES];

    div_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) div_dispatch_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .idle_i      (idle),
        .start_o     (start),
        .lane_req_o  (lane_req),
        .busy_o      (busy_o)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        div_lane div_lane_i (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .start_i (start[g]),
            .req_i   (lane_req),   // shared, only the started lane latches it
            .take_i  (take[g]),
            .idle_o  (idle[g]),
            .done_o  (done[g]),
            .res_o   (lane_res[g])
        );
    end

    div_collect #(
        .NUM_LANES (NUM_LANES)
    ) div_collect_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .done_i      (done),
        .lane_res_i  (lane_res),
        .take_o      (take),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the divide unit testbench, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module div_unit_tb \
    -f filelist.f -o div_unit_sim &&
./obj_dir/div_unit_sim | tee /dev/stderr | grep -q "^=== PASS ===$" &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }

//--- test/div_unit_assertions.sv
module div_unit_assertions #(
    parameter int NUM_LANES = 4
) (
    input logic                 clk_i,
    input logic                 rst_i,
    input logic [NUM_LANES-1:0] start_i,
    input logic [NUM_LANES-1:0] take_i,
    input logic [NUM_LANES-1:0] done_i,
    input logic                 res_valid_i
);
    timeunit 1ns;
    timeprecision 100ps;

    start_onehot: assert property (@(posedge clk_i) disable iff (!rst_i)
        $onehot0(start_i))
        else $error("start vector has more than one lane set");

    take_onehot: assert property (@(posedge clk_i) disable iff (!rst_i)
        $onehot0(take_i))
        else $error("take vector has more than one lane set");

    // collector may only drain a finished lane
    take_done: assert property (@(posedge clk_i) disable iff (!rst_i)
        (take_i & ~done_i) == '0)
        else $error("take issued to a lane that is not done");

    reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_i) |=> !res_valid_i)
        else $error("result valid right after reset release");

endmodule

bind div_unit_top div_unit_assertions #(
    .NUM_LANES (NUM_LANES)
) div_unit_assertions_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (start),
    .take_i      (take),
    .done_i      (done),
    .res_valid_i (res_valid_o)
);

//--- test/div_unit_tb.sv
module div_unit_tb import div_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_LANES      = 4;
    localparam int NUM_TAGS       = 2 ** DIV_TAG_W;
    localparam int NUM_OPS        = 100;   // rounded up from the test lists below
    localparam int CYCLES_PER_OP  = 40;
    localparam int TIMEOUT_CYCLES = NUM_OPS * CYCLES_PER_OP * 5;

    logic     clk_i;
    logic     rst_i;
    logic     req_valid_i;
    div_req_t req_i;
    logic     busy_o;
    logic     res_valid_o;
    div_res_t res_o;

    logic [31:0]         expected [NUM_TAGS];
    logic [NUM_TAGS-1:0] outstanding = '0;
    logic [31:0]         lfsr_q      = 32'h8bea_667d;
    logic [DIV_TAG_W-1:0] tag_next   = '0;
    logic                any_accepted = 1'b0;
    logic                expect_accept = 1'b0;   // burst requests must not see busy
    logic                drop_probe    = 1'b0;   // strobe sent while the lanes are full
    int                  n_sent        = 0;
    int                  n_returned    = 0;
    int                  cycles        = 0;

    div_unit_top #(
        .NUM_LANES (NUM_LANES)
    ) div_unit_top_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .busy_o      (busy_o),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    // M-extension rules with truncating division
    function automatic logic [31:0] expected_result(input div_req_t r);
        logic signed [31:0] a;
        logic signed [31:0] b;
        logic               is_rem;
        a      = r.dividend;
        b      = r.divisor;
        is_rem = (r.op == REM) || (r.op == REMU);
        if (r.divisor == 32'd0) begin
            return is_rem ? r.dividend : 32'hffff_ffff;
        end
        if (r.op == DIVU) begin
            return r.dividend / r.divisor;
        end
        if (r.op == REMU) begin
            return r.dividend % r.divisor;
        end
        if (r.dividend == 32'h8000_0000 && r.divisor == 32'hffff_ffff) begin
            return is_rem ? 32'd0 : r.dividend;
        end
        if (r.op == DIV) begin
            return a / b;
        end
        return a % b;
    endfunction

    always @(posedge clk_i) begin
        if (rst_i) begin
            if (res_valid_o) begin
                outstanding[res_o.tag] <= 1'b0;
                n_returned             <= n_returned + 1;
            end
            if (req_valid_i && !busy_o) begin
                expected[req_i.tag]    <= expected_result(req_i);
                outstanding[req_i.tag] <= 1'b1;
                any_accepted           <= 1'b1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with results still missing", cycles);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    check_result: assert property (@(posedge clk_i) disable iff (!rst_i)
        res_valid_o |-> (res_o.result == expected[res_o.tag]))
        else begin
            $display("[ERROR] %0d ns res_o.result expected %h got %h (tag %0d)", $time,
                     expected[$sampled(res_o.tag)], $sampled(res_o.result),
                     $sampled(res_o.tag));
            $display("=== FAIL ===");
            $fatal(1, "result mismatch");
        end

    check_tag: assert property (@(posedge clk_i) disable iff (!rst_i)
        res_valid_o |-> outstanding[res_o.tag])
        else begin
            $display("result with tag %0d at %0d ns has no open request with that tag",
                     $sampled(res_o.tag), $time);
            $display("=== FAIL ===");
            $fatal(1, "unexpected tag");
        end

    check_quiet_start: assert property (@(posedge clk_i) disable iff (!rst_i)
        !any_accepted |-> (!res_valid_o && !busy_o))
        else begin
            $display("res_valid_o or busy_o went high at %0d ns before any request", $time);
            $display("=== FAIL ===");
            $fatal(1, "activity before first request");
        end

    check_busy_full: assert property (@(posedge clk_i) disable iff (!rst_i)
        drop_probe |-> busy_o)
        else begin
            $display("busy_o was low at %0d ns although every lane was in use", $time);
            $display("=== FAIL ===");
            $fatal(1, "busy level");
        end

    check_busy_free: assert property (@(posedge clk_i) disable iff (!rst_i)
        (req_valid_i && expect_accept) |-> !busy_o)
        else begin
            $display("busy_o was high at %0d ns during the lane burst", $time);
            $display("=== FAIL ===");
            $fatal(1, "busy level");
        end

    // one strobe cycle from edge + 2 ns to the next edge + 2 ns
    task automatic drive_req(input div_op_e op, input logic [31:0] dvd,
                             input logic [31:0] dvs, input logic [DIV_TAG_W-1:0] tag);
        req_valid_i = 1'b1;
        req_i       = '{op: op, dividend: dvd, divisor: dvs, tag: tag};
        @(posedge clk_i);
        #2;
        req_valid_i = 1'b0;
    endtask

    task automatic issue(input div_op_e op, input logic [31:0] dvd, input logic [31:0] dvs);
        while (busy_o || outstanding[tag_next]) begin
            @(posedge clk_i);
            #2;
        end
        drive_req(op, dvd, dvs, tag_next);
        n_sent++;
        tag_next++;
    endtask

    task automatic drain();
        while (outstanding != '0) begin
            @(posedge clk_i);
        end
        #2;
    endtask

    initial begin
        logic [31:0] dvd;
        logic [31:0] dvs;
        logic [31:0] pick;
        logic [31:0] sh;
        div_op_e     op;

        rst_i       = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        repeat (4) @(posedge clk_i);
        #2;
        rst_i = 1'b1;
        repeat (5) @(posedge clk_i);   // quiet window after reset
        #2;

        for (int i = 0; i < 40; i++) begin   // unsigned
            pick = rand_bits(1);
            op   = pick[0] ? REMU : DIVU;
            dvd  = rand_bits(32);
            sh   = rand_bits(5);
            dvs  = rand_bits(32) >> sh;
            issue(op, dvd, dvs);
        end

        for (int i = 0; i < 40; i++) begin   // signed with the sign pair taken from i
            pick = rand_bits(1);
            op   = pick[0] ? REM : DIV;
            dvd  = rand_bits(31);
            sh   = rand_bits(5);
            dvs  = (rand_bits(31) >> sh) | 32'd1;
            if (i % 4 >= 2) begin
                dvd = -dvd;
            end
            if (i % 2 == 1) begin
                dvs = -dvs;
            end
            issue(op, dvd, dvs);
        end

        for (int k = 0; k < 4; k++) begin   // zero divisor
            issue(div_op_e'(k), rand_bits(32), 32'd0);
            issue(div_op_e'(k), 32'h8000_0000 | rand_bits(31), 32'd0);
        end

        issue(DIV, 32'h8000_0000, 32'hffff_ffff);
        issue(REM, 32'h8000_0000, 32'hffff_ffff);

        // fill every lane and send one strobe that must be dropped
        drain();
        expect_accept = 1'b1;
        for (int k = 0; k < NUM_LANES; k++) begin
            drive_req(DIVU, rand_bits(32), rand_bits(16) | 32'd1, DIV_TAG_W'(k));
            n_sent++;
        end
        expect_accept = 1'b0;
        drop_probe    = 1'b1;
        drive_req(DIVU, 32'd100, 32'd7, DIV_TAG_W'(NUM_LANES));
        drop_probe = 1'b0;

        drain();
        repeat (40) @(posedge clk_i);   // room for a stray result
        if (n_returned == n_sent) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("%0d results came back for %0d requests", n_returned, n_sent);
            $display("=== FAIL ===");
            $fatal(1, "result count");
        end
    end

endmodule
